/* Makefile */
TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
LINT_FLAGS = --lint-only --timing -Wall
TOP       = tb_bpm_event_proc
RTL_TOP   = bpm_event_proc
FILELIST  = filelist.f
BUILD     = obj_dir
LOG       = sim.log
PASS_MSG  = Simulation finished: PASS

SRCS     = $(shell grep -v '^+' $(FILELIST))
RTL_SRCS = $(filter src/%,$(SRCS))

.PHONY: all run lint clean

all: run

$(BUILD)/V$(TOP): $(SRCS) $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

run: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(BUILD) $(LOG)

/* bench/tb_bpm_event_proc.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_bpm_event_proc import bpm_pkg::*; ();

	localparam int NUM_ROWS = 12;
	localparam int SETTLE   = 12;   // last sample to last word visible, plus margin

	logic       clk;
	logic       RST_EVENT_NO;
	sample_t    sample_a, sample_b, sample_c, sample_d;
	logic       sample_valid;
	logic       sample_last;
	gain_t      gain_a, gain_b, gain_c, gain_d;
	logic       fifo_rd;
	word_t      fifo_dout;
	fifo_cnt_t  fifo_count;
	logic       fifo_empty;

	// event table, one row per event
	int     row_len   [NUM_ROWS];
	int     row_start [NUM_ROWS][NUM_CH];
	int     row_step  [NUM_ROWS][NUM_CH];
	gain_t  row_gain  [NUM_ROWS][NUM_CH];
	bit     row_drain [NUM_ROWS];   // pop everything after the event
	bit     row_reset [NUM_ROWS];   // reset pulse before the event

	// reference model state
	word_t  exp_q [$];
	int     model_count;
	int     model_evt;
	int     row_evt;
	bit     row_sent;

	integer seed = 32'h994a;
	int     check_cnt;
	int     err_cnt;
	int     cycle_cnt;
	int     cycle_limit;
	int     rs [4];

	bpm_event_proc u_bpm_event_proc (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
		.sample_a(sample_a), .sample_b(sample_b), .sample_c(sample_c), .sample_d(sample_d),
		.sample_valid(sample_valid), .sample_last(sample_last),
		.gain_a(gain_a), .gain_b(gain_b), .gain_c(gain_c), .gain_d(gain_d),
		.fifo_rd(fifo_rd),
		.fifo_dout(fifo_dout), .fifo_count(fifo_count), .fifo_empty(fifo_empty)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// run limit
	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= cycle_limit) begin
			$display("timeout after %0d cycles, DUT never finished the table", cycle_cnt);
			$display("Simulation finished: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////
	// compare tasks
	////////////////////////////////////////
	task automatic check_word(input string name, input word_t got, input word_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input fifo_cnt_t got, input fifo_cnt_t exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("FAIL t=%0t %s: got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		check_cnt++;
		if (got !== exp) begin
			err_cnt++;
			$display("FAIL t=%0t %s: got %b expected %b", $time, name, got, exp);
		end
	endtask

	task automatic set_row(input int r, input int len,
		input int s_a, input int s_b, input int s_c, input int s_d,
		input int d_a, input int d_b, input int d_c, input int d_d,
		input gain_t g_a, input gain_t g_b, input gain_t g_c, input gain_t g_d,
		input bit drain, input bit rst);
		row_len[r]   = len;
		row_start[r] = '{s_a, s_b, s_c, s_d};
		row_step[r]  = '{d_a, d_b, d_c, d_d};
		row_gain[r]  = '{g_a, g_b, g_c, g_d};
		row_drain[r] = drain;
		row_reset[r] = rst;
	endtask

	// ramp sample, clamped to adc range
	function automatic sample_t ramp_sample(input int r, input int ch, input int i);
		longint v;
		v = longint'(row_start[r][ch]) + longint'(i) * longint'(row_step[r][ch]);
		if (v > 32767)
			v = 32767;
		else if (v < -32768)
			v = -32768;
		return sample_t'(v);
	endfunction

	////////////////////////////////////////
	// reference model
	////////////////////////////////////////
	task automatic model_event(input int r);
		longint             acc [NUM_CH];
		longint             pk  [NUM_CH];
		longint             v;
		longint             prod;
		word_t              adj [NUM_CH];
		logic [NUM_CH-1:0]  ov;
		ov = '0;
		for (int ch = 0; ch < NUM_CH; ch++) begin
			acc[ch] = 0;
			pk[ch]  = ramp_sample(r, ch, 0);
			for (int i = 0; i < row_len[r]; i++) begin
				v = ramp_sample(r, ch, i);   // sign extended
				acc[ch] += v * v;
				if (v > pk[ch])
					pk[ch] = v;
				if (v == 32767 || v == -32768)
					ov[NUM_CH-1-ch] = 1'b1;   // a on top
			end
			prod = longint'(power_t'(acc[ch] >> 16)) * longint'(row_gain[r][ch]);
			prod = prod >> 15;
			adj[ch] = (prod > 64'h0000_0000_ffff_ffff) ? 32'hffff_ffff : word_t'(prod);
		end
		row_evt  = model_evt;
		row_sent = (model_count <= SFIFO_DEPTH - PACKET_WORDS);  // room rule
		if (row_sent) begin
			exp_q.push_back(32'h4142504d);
			exp_q.push_back({ov, 12'h000, evt_num_t'(model_evt)});
			exp_q.push_back({sample_t'(pk[0]), sample_t'(pk[1])});
			exp_q.push_back({sample_t'(pk[2]), sample_t'(pk[3])});
			for (int ch = 0; ch < NUM_CH; ch++)
				exp_q.push_back(adj[ch]);
			model_count += PACKET_WORDS;
		end
		model_evt++;   // dropped events count too
	endtask

	////////////////////////////////////////
	// stimulus
	////////////////////////////////////////
	task automatic play_event(input int r);
		gain_a = row_gain[r][0];
		gain_b = row_gain[r][1];
		gain_c = row_gain[r][2];
		gain_d = row_gain[r][3];
		for (int i = 0; i < row_len[r]; i++) begin
			@(negedge clk);
			sample_a     = ramp_sample(r, 0, i);
			sample_b     = ramp_sample(r, 1, i);
			sample_c     = ramp_sample(r, 2, i);
			sample_d     = ramp_sample(r, 3, i);
			sample_valid = 1'b1;
			sample_last  = (i == row_len[r] - 1);
		end
		@(negedge clk);
		sample_valid = 1'b0;
		sample_last  = 1'b0;
	endtask

	// pop until the model queue is empty
	task automatic drain_fifo();
		word_t exp;
		while (exp_q.size() > 0) begin
			exp = exp_q.pop_front();
			check_word("fifo_dout", fifo_dout, exp);   // head before the pop
			fifo_rd = 1'b1;
			@(negedge clk);
		end
		// one more pop on the empty fifo, ignored by the DUT
		fifo_rd = 1'b1;
		@(negedge clk);
		fifo_rd     = 1'b0;
		model_count = 0;
	endtask

	task automatic pulse_reset();
		RST_EVENT_NO = 1'b1;
		repeat (4) @(negedge clk);
		RST_EVENT_NO = 1'b0;
		exp_q.delete();
		model_count = 0;
		model_evt   = 0;
	endtask

	initial begin
		RST_EVENT_NO = 1'b1;
		sample_a     = '0;
		sample_b     = '0;
		sample_c     = '0;
		sample_d     = '0;
		sample_valid = 1'b0;
		sample_last  = 1'b0;
		gain_a       = 16'h8000;
		gain_b       = 16'h8000;
		gain_c       = 16'h8000;
		gain_d       = 16'h8000;
		fifo_rd      = 1'b0;
		check_cnt    = 0;
		err_cnt      = 0;
		cycle_cnt    = 0;
		model_count  = 0;
		model_evt    = 0;

		// plain event, unity gains
		set_row(0, 8, 100, 200, 300, 400, 10, 20, 30, 40,
			16'h8000, 16'h8000, 16'h8000, 16'h8000, 1, 0);
		// rising, falling, negative falling, negative ramp
		set_row(1, 16, -1000, 5000, -20000, -3, 300, -250, -100, -37,
			16'h4000, 16'h8000, 16'hc000, 16'h2000, 1, 0);
		// a hits +full scale, b hits -full scale
		set_row(2, 6, 32000, -32000, 1000, -5, 300, -300, 0, -2,
			16'h8000, 16'h8000, 16'h8000, 16'h8000, 1, 0);
		// long rail event, gains near 2.0 saturate
		set_row(3, 140000, -32768, -32768, -32768, -32768, 0, 0, 0, 0,
			16'hffff, 16'hffff, 16'hfff0, 16'h8000, 1, 0);
		// rows 4..7 fill the fifo, row 8 is dropped
		for (int k = 0; k < 4; k++)
			rs[k] = $signed($random(seed)) % 20000;
		set_row(4, 10, rs[0], rs[1], rs[2], rs[3], 7, -7, 13, -13,
			16'h8000, 16'h7000, 16'h9000, 16'h8000, 0, 0);
		set_row(5, 5, 1, -2, 3, -4, 500, -500, 1000, -1000,
			16'h8000, 16'h8000, 16'h8000, 16'h8000, 0, 0);
		for (int k = 0; k < 4; k++)
			rs[k] = $signed($random(seed)) % 20000;
		set_row(6, 12, rs[0], rs[1], rs[2], rs[3], -11, 11, -5, 5,
			16'h1234, 16'h8000, 16'hf000, 16'h0800, 0, 0);
		set_row(7, 4, 2000, 2000, 2000, 2000, 1, 2, 3, 4,
			16'h8000, 16'h8000, 16'h8000, 16'h8000, 0, 0);
		set_row(8, 9, 50, 60, 70, 80, 5, 5, 5, 5,
			16'h8000, 16'h8000, 16'h8000, 16'h8000, 1, 0);
		// numbered one past the dropped event
		set_row(9, 7, -400, 400, -800, 800, 20, -20, 40, -40,
			16'h8000, 16'h8000, 16'h8000, 16'h8000, 1, 0);
		// left queued for the reset
		set_row(10, 5, 3000, -3000, 123, -456, -100, 100, 7, -7,
			16'h6000, 16'ha000, 16'h8000, 16'h4000, 0, 0);
		// reset with a packet still queued
		set_row(11, 6, 10, 20, 30, 40, 1, 1, 1, 1,
			16'h8000, 16'h8000, 16'h8000, 16'h8000, 1, 1);

		cycle_limit = 40 * NUM_ROWS;
		for (int r = 0; r < NUM_ROWS; r++)
			cycle_limit += row_len[r];

		repeat (4) @(posedge clk);
		@(negedge clk);
		RST_EVENT_NO = 1'b0;

		for (int r = 0; r < NUM_ROWS; r++) begin
			if (row_reset[r]) begin
				pulse_reset();
				check_count("fifo_count", fifo_count, '0);
				check_flag("fifo_empty", fifo_empty, 1'b1);
			end
			model_event(r);
			play_event(r);
			repeat (SETTLE) @(negedge clk);   // packet fully written by now
			check_count("fifo_count", fifo_count, fifo_cnt_t'(model_count));
			check_flag("fifo_empty", fifo_empty, model_count == 0);
			if (row_drain[r]) begin
				drain_fifo();
				check_count("fifo_count", fifo_count, '0);
				check_flag("fifo_empty", fifo_empty, 1'b1);
			end
			$display("row %0d: len %0d, event %0d %s, errors so far %0d",
				r, row_len[r], row_evt, row_sent ? "sent" : "dropped", err_cnt);
		end

		$display("checks %0d, errors %0d, cycles %0d", check_cnt, err_cnt, cycle_cnt);
		if (err_cnt == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
src/bpm_pkg.sv
src/peak_tracker.sv
src/power_accum.sv
src/gain_adjust.sv
src/packet_builder.sv
src/slow_fifo.sv
src/bpm_event_proc.sv
bench/tb_bpm_event_proc.sv

/* src/bpm_event_proc.sv */
`timescale 1ns/1ps
`default_nettype none

module bpm_event_proc import bpm_pkg::*; (
	input  wire             clk,
	input  wire             RST_EVENT_NO,
	input  wire sample_t    sample_a,
	input  wire sample_t    sample_b,
	input  wire sample_t    sample_c,
	input  wire sample_t    sample_d,
	input  wire             sample_valid,
	input  wire             sample_last,
	input  wire gain_t      gain_a,
	input  wire gain_t      gain_b,
	input  wire gain_t      gain_c,
	input  wire gain_t      gain_d,
	input  wire             fifo_rd,
	output wire word_t      fifo_dout,
	output wire fifo_cnt_t  fifo_count,
	output wire             fifo_empty
);

	// peak path
	wire sample_t           peak_a, peak_b, peak_c, peak_d;
	wire [NUM_CH-1:0]       ovf;
	// power path
	wire power_t            power_a, power_b, power_c, power_d;
	wire                    power_rdy;
	wire power_t            adj_a, adj_b, adj_c, adj_d;
	wire                    adj_rdy;
	// packer to fifo
	wire                    fifo_wr;
	wire word_t             fifo_din;

	////////////////////////////////////////
	// per sample
	////////////////////////////////////////
	peak_tracker u_peak_tracker (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
		.sample_valid(sample_valid), .sample_last(sample_last),
		.sample_a(sample_a), .sample_b(sample_b), .sample_c(sample_c), .sample_d(sample_d),
		.peak_a(peak_a), .peak_b(peak_b), .peak_c(peak_c), .peak_d(peak_d),
		.ovf(ovf)
	);

	power_accum u_power_accum (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
		.sample_valid(sample_valid), .sample_last(sample_last),
		.sample_a(sample_a), .sample_b(sample_b), .sample_c(sample_c), .sample_d(sample_d),
		.power_a(power_a), .power_b(power_b), .power_c(power_c), .power_d(power_d),
		.power_rdy(power_rdy)  // last + 1
	);

	////////////////////////////////////////
	// per event
	////////////////////////////////////////
	gain_adjust u_gain_adjust (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
		.power_rdy(power_rdy),
		.power_a(power_a), .power_b(power_b), .power_c(power_c), .power_d(power_d),
		.gain_a(gain_a), .gain_b(gain_b), .gain_c(gain_c), .gain_d(gain_d),
		.adj_a(adj_a), .adj_b(adj_b), .adj_c(adj_c), .adj_d(adj_d),
		.adj_rdy(adj_rdy)      // last + 3
	);

	packet_builder u_packet_builder (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
		.adj_rdy(adj_rdy),
		.adj_a(adj_a), .adj_b(adj_b), .adj_c(adj_c), .adj_d(adj_d),
		.peak_a(peak_a), .peak_b(peak_b), .peak_c(peak_c), .peak_d(peak_d),
		.ovf(ovf),
		.fifo_count(fifo_count),
		.fifo_wr(fifo_wr),     // last + 4, 8 cycles
		.fifo_din(fifo_din)
	);

	slow_fifo u_slow_fifo (
		.clk(clk), .RST_EVENT_NO(RST_EVENT_NO),
		.fifo_wr(fifo_wr), .fifo_din(fifo_din),
		.fifo_rd(fifo_rd),
		.fifo_dout(fifo_dout), .fifo_count(fifo_count), .fifo_empty(fifo_empty)
	);

endmodule

`default_nettype wire

/* src/bpm_pkg.sv */
`default_nettype none

package bpm_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////
	localparam int NUM_CH       = 4;    // electrodes a..d
	localparam int SAMPLE_W     = 16;
	localparam int ACC_W        = 48;   // sum of squares
	localparam int POWER_W      = 32;   // top bits of the accumulator
	localparam int GAIN_W       = 16;
	localparam int GAIN_SHIFT   = 15;   // 1.15 gain, 0x8000 is unity
	localparam int WORD_W       = 32;
	localparam int EVT_W        = 16;
	localparam int STATUS_W     = 16;

	// slow fifo and packet
	localparam int SFIFO_DEPTH  = 32;
	localparam int PACKET_WORDS = 8;
	localparam int FIFO_CNT_W   = $clog2(SFIFO_DEPTH) + 1; // holds 0..depth

	////////////////////////////////////////
	// types
	////////////////////////////////////////
	typedef logic signed [SAMPLE_W-1:0]         sample_t;
	typedef logic        [ACC_W-1:0]            acc_t;
	typedef logic        [POWER_W-1:0]          power_t;
	typedef logic        [GAIN_W-1:0]           gain_t;
	typedef logic        [WORD_W-1:0]           word_t;
	typedef logic        [EVT_W-1:0]            evt_num_t;
	typedef logic        [STATUS_W-1:0]         status_t;
	typedef logic        [FIFO_CNT_W-1:0]       fifo_cnt_t;
	typedef logic [$clog2(SFIFO_DEPTH)-1:0]     fifo_ptr_t;  // wraps on its own
	typedef logic [$clog2(PACKET_WORDS)-1:0]    word_idx_t;

	// packet header word, ascii "ABPM"
	localparam word_t PACKET_ID = 32'h4142504d;

	// adc full scale, either rail flags overflow
	localparam sample_t SAMPLE_MAX = 16'sh7fff;
	localparam sample_t SAMPLE_MIN = 16'sh8000;

	// packer fsm
	typedef enum logic {
		PACK_IDLE,   // waiting for adj_rdy
		PACK_SEND    // streaming the 8 words
	} pack_state_t;

endpackage

`default_nettype wire

/* src/gain_adjust.sv */
`timescale 1ns/1ps
`default_nettype none

module gain_adjust import bpm_pkg::*; (
	input  wire          clk,
	input  wire          RST_EVENT_NO,
	input  wire          power_rdy,
	input  wire power_t  power_a,
	input  wire power_t  power_b,
	input  wire power_t  power_c,
	input  wire power_t  power_d,
	input  wire gain_t   gain_a,
	input  wire gain_t   gain_b,
	input  wire gain_t   gain_c,
	input  wire gain_t   gain_d,
	output power_t       adj_a,
	output power_t       adj_b,
	output power_t       adj_c,
	output power_t       adj_d,
	output logic         adj_rdy
);

	power_t                                 pwr    [NUM_CH];
	gain_t                                  gain   [NUM_CH];
	logic [POWER_W+GAIN_W-1:0]              prod   [NUM_CH]; // stage one
	logic [POWER_W+GAIN_W-GAIN_SHIFT-1:0]   scaled [NUM_CH]; // 33 bits after shift
	power_t                                 adj    [NUM_CH]; // stage two
	logic                                   v1;
	logic                                   v2;

	assign pwr[0]  = power_a;
	assign pwr[1]  = power_b;
	assign pwr[2]  = power_c;
	assign pwr[3]  = power_d;
	assign gain[0] = gain_a;
	assign gain[1] = gain_b;
	assign gain[2] = gain_c;
	assign gain[3] = gain_d;

	// stage valids
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
		end else begin
			v1 <= power_rdy;
			v2 <= v1;
		end
	end

	always_comb begin
		for (int i = 0; i < NUM_CH; i++)
			scaled[i] = prod[i][POWER_W+GAIN_W-1:GAIN_SHIFT];  // >> GAIN_SHIFT
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < NUM_CH; i++) begin
			if (power_rdy)
				prod[i] <= pwr[i] * gain[i];
			if (v1)
				adj[i] <= scaled[i][POWER_W] ? '1 : scaled[i][POWER_W-1:0];  // clip at max
		end
	end

	assign adj_rdy = v2;  // power_rdy + 2
	assign adj_a   = adj[0];
	assign adj_b   = adj[1];
	assign adj_c   = adj[2];
	assign adj_d   = adj[3];

endmodule

`default_nettype wire

/* src/packet_builder.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_builder import bpm_pkg::*; (
	input  wire                     clk,
	input  wire                     RST_EVENT_NO,
	input  wire                     adj_rdy,
	input  wire power_t             adj_a,
	input  wire power_t             adj_b,
	input  wire power_t             adj_c,
	input  wire power_t             adj_d,
	input  wire sample_t            peak_a,
	input  wire sample_t            peak_b,
	input  wire sample_t            peak_c,
	input  wire sample_t            peak_d,
	input  wire [NUM_CH-1:0]        ovf,
	input  wire fifo_cnt_t          fifo_count,
	output logic                    fifo_wr,
	output word_t                   fifo_din
);

	pack_state_t  state;
	word_idx_t    idx;           // word being written
	evt_num_t     evt_num;
	evt_num_t     snap_evt;
	status_t      snap_status;
	sample_t      snap_peak [NUM_CH];
	power_t       snap_adj  [NUM_CH];
	logic         room;
	logic         accept;

	// whole packet must fit, else event dropped
	assign room   = fifo_count <= fifo_cnt_t'(SFIFO_DEPTH - PACKET_WORDS);
	assign accept = adj_rdy && (state == PACK_IDLE) && room;

	// counts sent and dropped events alike
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO)
			evt_num <= '0;
		else if (adj_rdy)
			evt_num <= evt_num + 1'b1;
	end

	////////////////////////////////////////
	// packer fsm
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			state <= PACK_IDLE;
			idx   <= '0;
		end else begin
			case (state)
				PACK_IDLE: begin
					idx <= '0;
					if (accept)
						state <= PACK_SEND;
				end
				PACK_SEND: begin
					idx <= idx + 1'b1;
					if (idx == word_idx_t'(PACKET_WORDS - 1))
						state <= PACK_IDLE;  // last word this cycle
				end
				default: state <= PACK_IDLE;
			endcase
		end
	end

	// snapshot, number taken before its increment
	always_ff @(posedge clk) begin
		if (accept) begin
			snap_evt     <= evt_num;
			snap_status  <= {ovf, {(STATUS_W - NUM_CH){1'b0}}};
			snap_peak[0] <= peak_a;
			snap_peak[1] <= peak_b;
			snap_peak[2] <= peak_c;
			snap_peak[3] <= peak_d;
			snap_adj[0]  <= adj_a;
			snap_adj[1]  <= adj_b;
			snap_adj[2]  <= adj_c;
			snap_adj[3]  <= adj_d;
		end
	end

	assign fifo_wr = (state == PACK_SEND);  // adj_rdy + 1 for word 0

	always_comb begin
		case (idx)
			3'd0:    fifo_din = PACKET_ID;
			3'd1:    fifo_din = {snap_status, snap_evt};
			3'd2:    fifo_din = {snap_peak[0], snap_peak[1]};
			3'd3:    fifo_din = {snap_peak[2], snap_peak[3]};
			3'd4:    fifo_din = snap_adj[0];
			3'd5:    fifo_din = snap_adj[1];
			3'd6:    fifo_din = snap_adj[2];
			default: fifo_din = snap_adj[3];  // word 7
		endcase
	end

endmodule

`default_nettype wire

/* src/peak_tracker.sv */
`timescale 1ns/1ps
`default_nettype none

module peak_tracker import bpm_pkg::*; (
	input  wire                clk,
	input  wire                RST_EVENT_NO,
	input  wire                sample_valid,
	input  wire                sample_last,
	input  wire sample_t       sample_a,
	input  wire sample_t       sample_b,
	input  wire sample_t       sample_c,
	input  wire sample_t       sample_d,
	output sample_t            peak_a,
	output sample_t            peak_b,
	output sample_t            peak_c,
	output sample_t            peak_d,
	output logic [NUM_CH-1:0]  ovf       // bit 3 is a, bit 0 is d
);

	sample_t            smp     [NUM_CH];  // index 0 is a
	sample_t            run_max [NUM_CH];
	sample_t            nxt_max [NUM_CH];
	sample_t            peak    [NUM_CH];  // held until next event ends
	logic [NUM_CH-1:0]  run_ovf;
	logic [NUM_CH-1:0]  nxt_ovf;
	logic               first;             // next valid sample opens an event

	assign smp[0] = sample_a;
	assign smp[1] = sample_b;
	assign smp[2] = sample_c;
	assign smp[3] = sample_d;

	// running max restarts on the first sample
	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			if (first || (smp[i] > run_max[i]))
				nxt_max[i] = smp[i];
			else
				nxt_max[i] = run_max[i];
			// ovf bits run a..d from msb down
			nxt_ovf[NUM_CH-1-i] = (!first && run_ovf[NUM_CH-1-i]) ||
				(smp[i] == SAMPLE_MAX) || (smp[i] == SAMPLE_MIN);
		end
	end

	always_ff @(posedge clk) begin
		if (RST_EVENT_NO)
			first <= 1'b1;
		else if (sample_valid)
			first <= sample_last;   // last sample closes the event
	end

	always_ff @(posedge clk) begin
		if (sample_valid) begin
			run_max <= nxt_max;
			run_ovf <= nxt_ovf;
			if (sample_last) begin
				peak <= nxt_max;    // results for this event
				ovf  <= nxt_ovf;
			end
		end
	end

	assign peak_a = peak[0];
	assign peak_b = peak[1];
	assign peak_c = peak[2];
	assign peak_d = peak[3];

endmodule

`default_nettype wire

/* src/power_accum.sv */
`timescale 1ns/1ps
`default_nettype none

module power_accum import bpm_pkg::*; (
	input  wire           clk,
	input  wire           RST_EVENT_NO,
	input  wire           sample_valid,
	input  wire           sample_last,
	input  wire sample_t  sample_a,
	input  wire sample_t  sample_b,
	input  wire sample_t  sample_c,
	input  wire sample_t  sample_d,
	output power_t        power_a,
	output power_t        power_b,
	output power_t        power_c,
	output power_t        power_d,
	output logic          power_rdy
);

	sample_t                 smp     [NUM_CH];
	logic [2*SAMPLE_W-1:0]   sq      [NUM_CH];  // never negative, max 2^30
	acc_t                    acc     [NUM_CH];
	acc_t                    acc_nxt [NUM_CH];
	power_t                  pwr     [NUM_CH];

	assign smp[0] = sample_a;
	assign smp[1] = sample_b;
	assign smp[2] = sample_c;
	assign smp[3] = sample_d;

	////////////////////////////////////////
	// square and add
	////////////////////////////////////////
	always_comb begin
		for (int i = 0; i < NUM_CH; i++) begin
			sq[i]      = smp[i] * smp[i];        // signed multiply
			acc_nxt[i] = acc[i] + acc_t'(sq[i]); // zero extended
		end
	end

	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			power_rdy <= 1'b0;
			for (int i = 0; i < NUM_CH; i++)
				acc[i] <= '0;
		end else begin
			power_rdy <= sample_valid && sample_last;  // one cycle after last
			if (sample_valid) begin
				for (int i = 0; i < NUM_CH; i++)
					acc[i] <= sample_last ? '0 : acc_nxt[i];  // restart per event
			end
		end
	end

	// scaled power, top 32 of 48 bits
	always_ff @(posedge clk) begin
		if (sample_valid && sample_last) begin
			for (int i = 0; i < NUM_CH; i++)
				pwr[i] <= acc_nxt[i][ACC_W-1 -: POWER_W];
		end
	end

	assign power_a = pwr[0];
	assign power_b = pwr[1];
	assign power_c = pwr[2];
	assign power_d = pwr[3];

endmodule

`default_nettype wire

/* src/slow_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module slow_fifo import bpm_pkg::*; (
	input  wire          clk,
	input  wire          RST_EVENT_NO,
	input  wire          fifo_wr,
	input  wire word_t   fifo_din,
	input  wire          fifo_rd,
	output word_t        fifo_dout,
	output fifo_cnt_t    fifo_count,
	output logic         fifo_empty
);

	word_t      mem [SFIFO_DEPTH];
	fifo_ptr_t  wr_ptr;
	fifo_ptr_t  rd_ptr;
	logic       do_wr;
	logic       do_rd;

	assign do_wr      = fifo_wr;                  // packer only starts when a packet fits
	assign do_rd      = fifo_rd && !fifo_empty;   // pop on empty ignored
	assign fifo_empty = (fifo_count == '0);
	assign fifo_dout  = mem[rd_ptr];              // head word, fall through

	////////////////////////////////////////
	// pointers and occupancy
	////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (RST_EVENT_NO) begin
			wr_ptr     <= '0;
			rd_ptr     <= '0;
			fifo_count <= '0;
		end else begin
			if (do_wr)
				wr_ptr <= wr_ptr + 1'b1;  // depth is a power of two
			if (do_rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_wr, do_rd})
				2'b10:   fifo_count <= fifo_count + 1'b1;
				2'b01:   fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count;  // both or neither
			endcase
		end
	end

	// storage
	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wr_ptr] <= fifo_din;
	end

endmodule

`default_nettype wire
